// ==== all.f ====
+incdir+hw
hw/bus_pkg.sv
hw/ram_16kx16.sv
hw/dma_fill.sv
hw/iopage.sv
hw/bus.sv
test/tb_clock.sv
test/bus_checker.sv
test/tb_bus.sv

// ==== hw/bus.sv ====
/*
 * pdp-11 memory and i/o bus: cpu/dma arbiter, ram and
 * i/o page address split, ram port mux
 */
`timescale 1ns/1ps
`default_nettype none

module bus
(
   input  wire                clk,
   input  wire                reset,
   input  bus_pkg::cpu_bus_t  cpu,
   input  wire         [15:0] psw,
   input  wire         [15:0] switches,
   output logic        [15:0] data_out,
   output logic               bus_ack,
   output logic               bus_error,
   output logic               interrupt,
   output logic         [7:0] vector,
   output logic               psw_io_wr,
   output logic        [15:0] display
);

   import bus_pkg::*;

   logic        grant_dma;
   logic        ram_access;
   logic        cpu_rd;
   logic        cpu_wr;
   logic        io_rd;
   logic        io_wr;
   logic        dma_req;
   dma_bus_t    dma;
   logic        ram_ce;
   logic        ram_we;
   logic        ram_byte_op;
   logic [15:0] ram_addr;
   logic [15:0] ram_data_in;
   logic [15:0] ram_data_out;
   logic [15:0] io_data_out;

   // two-state arbiter, dma never holds the bus two cycles running
   always_ff @(posedge clk)
   begin
      if (reset)
         grant_dma <= 1'b0;
      else
         grant_dma <= dma_req && !grant_dma;
   end

   assign bus_ack = !grant_dma;

   // i/o page is the top 8 KB of the 16-bit space
   assign ram_access = !(&cpu.addr[15:13]);

   // cpu strobes only count while the cpu holds the grant
   assign cpu_rd = cpu.rd && bus_ack;
   assign cpu_wr = cpu.wr && bus_ack;
   assign io_rd  = cpu_rd && !ram_access;
   assign io_wr  = cpu_wr && !ram_access;

   assign ram_ce = ((cpu_rd || cpu_wr) && ram_access) || dma.rd || dma.wr;
   assign ram_we = (cpu_wr && ram_access) || dma.wr;

   assign ram_addr    = grant_dma ? dma.addr[15:0] : cpu.addr[15:0];
   assign ram_data_in = grant_dma ? dma.data : cpu.data;
   assign ram_byte_op = grant_dma ? 1'b0 : cpu.byte_op;

   assign data_out = ram_access ? ram_data_out : io_data_out;

   ram_16kx16 i_ram
   (
      .clk      (clk),
      .ce       (ram_ce),
      .we       (ram_we),
      .byte_op  (ram_byte_op),
      .addr     (ram_addr),
      .data_in  (ram_data_in),
      .data_out (ram_data_out)
   );

   iopage i_iopage
   (
      .clk         (clk),
      .reset       (reset),
      .cpu         (cpu),
      .rd          (io_rd),
      .wr          (io_wr),
      .psw         (psw),
      .switches    (switches),
      .dma_ack     (grant_dma),
      .dma_data_in (ram_data_out),
      .data_out    (io_data_out),
      .no_decode   (bus_error),
      .interrupt   (interrupt),
      .vector      (vector),
      .psw_io_wr   (psw_io_wr),
      .display     (display),
      .dma_req     (dma_req),
      .dma         (dma)
   );

endmodule

`default_nettype wire

// ==== hw/bus_consts.svh ====
/*
 * i/o page register addresses and fill device constants
 * for the pdp-11 memory and i/o bus
 */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// processor status word and switch/display register
`define BUS_PSW_ADDR        16'o177776
`define BUS_SWR_ADDR        16'o177570

// memory-fill dma device registers
`define BUS_FILL_ADDR_REG   16'o177700
`define BUS_FILL_COUNT_REG  16'o177702
`define BUS_FILL_DATA_REG   16'o177704
`define BUS_FILL_CSR_REG    16'o177706

`define BUS_FILL_VECTOR     8'o220

// fill csr bits
`define BUS_FILL_GO_BIT     0
`define BUS_FILL_IE_BIT     6
`define BUS_FILL_DONE_BIT   7

`define BUS_RAM_WORDS       16384

`endif

// ==== hw/bus_pkg.sv ====
/*
 * bus request types shared by the cpu side, the i/o page
 * and the dma devices
 */
`default_nettype none

package bus_pkg;

   // one cpu bus cycle, held until bus_ack
   typedef struct packed
   {
      logic [21:0] addr;
      logic [15:0] data;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } cpu_bus_t;

   // dma memory request from an i/o page device
   // word access only, no byte lanes
   typedef struct packed
   {
      logic [17:0] addr;
      logic [15:0] data;
      logic        rd;
      logic        wr;
   } dma_bus_t;

endpackage

`default_nettype wire

// ==== hw/dma_fill.sv ====
/*
 * memory-fill dma device: writes a pattern into a block of
 * ram words, then flags done and interrupts with its vector
 */
`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module dma_fill
(
   input  wire                clk,
   input  wire                reset,
   input  wire          [1:0] reg_sel,
   input  wire                reg_wr,
   input  wire         [15:0] reg_data,
   input  wire                dma_ack,
   output logic        [15:0] reg_rdata,
   output logic               dma_req,
   output bus_pkg::dma_bus_t  dma,
   output logic               interrupt,
   output logic         [7:0] vector
);

   logic [15:0] fill_addr;
   logic [15:0] fill_count;
   logic [15:0] fill_data;
   logic        busy;
   logic        done;
   logic        int_enable;
   logic        step;
   logic [15:0] csr_value;

   // one word per granted cycle
   assign step = busy && dma_ack && (fill_count != 16'd0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fill_addr  <= 16'd0;
         fill_count <= 16'd0;
         fill_data  <= 16'd0;
         busy       <= 1'b0;
         done       <= 1'b0;
         int_enable <= 1'b0;
      end
      else
      begin
         if (step)
         begin
            fill_addr  <= fill_addr + 16'd2;
            fill_count <= fill_count - 16'd1;
         end
         if (busy && (fill_count == 16'd0))
         begin
            busy <= 1'b0;
            done <= 1'b1;
         end
         // register writes win over stepping
         if (reg_wr)
         begin
            case (reg_sel)
               2'd0: fill_addr <= reg_data;
               2'd1: fill_count <= reg_data;
               2'd2: fill_data <= reg_data;
               default:
               begin
                  int_enable <= reg_data[`BUS_FILL_IE_BIT];
                  done       <= 1'b0;
                  if (reg_data[`BUS_FILL_GO_BIT])
                     busy <= 1'b1;
               end
            endcase
         end
      end
   end

   always_comb
   begin
      csr_value = 16'd0;
      csr_value[`BUS_FILL_GO_BIT]   = busy;
      csr_value[`BUS_FILL_IE_BIT]   = int_enable;
      csr_value[`BUS_FILL_DONE_BIT] = done;
   end

   always_comb
   begin
      case (reg_sel)
         2'd0: reg_rdata = fill_addr;
         2'd1: reg_rdata = fill_count;
         2'd2: reg_rdata = fill_data;
         default: reg_rdata = csr_value;
      endcase
   end

   assign dma_req = busy && (fill_count != 16'd0);

   always_comb
   begin
      dma.addr = {2'b00, fill_addr};
      dma.data = fill_data;
      dma.rd   = 1'b0;
      dma.wr   = step;
   end

   assign interrupt = done && int_enable;
   assign vector    = interrupt ? `BUS_FILL_VECTOR : 8'd0;

endmodule

`default_nettype wire

// ==== hw/iopage.sv ====
/*
 * i/o page decoder: psw access, switch and display register,
 * memory-fill dma device; flags unmapped addresses
 */
`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module iopage
(
   input  wire                clk,
   input  wire                reset,
   input  bus_pkg::cpu_bus_t  cpu,
   input  wire                rd,
   input  wire                wr,
   input  wire         [15:0] psw,
   input  wire         [15:0] switches,
   input  wire                dma_ack,
   input  wire         [15:0] dma_data_in,
   output logic        [15:0] data_out,
   output logic               no_decode,
   output logic               interrupt,
   output logic         [7:0] vector,
   output logic               psw_io_wr,
   output logic        [15:0] display,
   output logic               dma_req,
   output bus_pkg::dma_bus_t  dma
);

   logic [15:0] word_addr;
   logic        sel_psw;
   logic        sel_swr;
   logic        sel_fill;
   logic        fill_wr;
   logic [15:0] fill_rdata;

   // registers decode on the word address so byte accesses hit too
   assign word_addr = {cpu.addr[15:1], 1'b0};

   assign sel_psw  = (word_addr == `BUS_PSW_ADDR);
   assign sel_swr  = (word_addr == `BUS_SWR_ADDR);
   assign sel_fill = (word_addr == `BUS_FILL_ADDR_REG) ||
                     (word_addr == `BUS_FILL_COUNT_REG) ||
                     (word_addr == `BUS_FILL_DATA_REG) ||
                     (word_addr == `BUS_FILL_CSR_REG);

   assign fill_wr   = wr && sel_fill;
   assign psw_io_wr = wr && sel_psw;
   assign no_decode = (rd || wr) && !(sel_psw || sel_swr || sel_fill);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         display <= 16'd0;
      end
      else if (wr && sel_swr)
      begin
         if (cpu.byte_op)
         begin
            if (cpu.addr[0])
               display[15:8] <= cpu.data[7:0];
            else
               display[7:0] <= cpu.data[7:0];
         end
         else
         begin
            display <= cpu.data;
         end
      end
   end

   always_comb
   begin
      // during a dma read the ram word is put on the i/o data path
      if (dma_ack && dma.rd)
         data_out = dma_data_in;
      else if (sel_psw)
         data_out = psw;
      else if (sel_swr)
         data_out = switches;
      else if (sel_fill)
         data_out = fill_rdata;
      else
         data_out = 16'd0;
   end

   dma_fill i_dma_fill
   (
      .clk       (clk),
      .reset     (reset),
      .reg_sel   (word_addr[2:1]),
      .reg_wr    (fill_wr),
      .reg_data  (cpu.data),
      .dma_ack   (dma_ack),
      .reg_rdata (fill_rdata),
      .dma_req   (dma_req),
      .dma       (dma),
      .interrupt (interrupt),
      .vector    (vector)
   );

endmodule

`default_nettype wire

// ==== hw/ram_16kx16.sv ====
/*
 * 16k x 16 word ram, combinational read, clocked write,
 * byte lane writes selected by address bit 0
 */
`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module ram_16kx16
(
   input  wire         clk,
   input  wire         ce,
   input  wire         we,
   input  wire         byte_op,
   input  wire  [15:0] addr,
   input  wire  [15:0] data_in,
   output logic [15:0] data_out
);

   logic [15:0] mem [0:`BUS_RAM_WORDS-1];
   logic [13:0] word_index;

   // byte address to word index, upper half aliases
   assign word_index = addr[14:1];

   always_comb
   begin
      if (ce)
         data_out = mem[word_index];
      else
         data_out = 16'd0;
   end

   always_ff @(posedge clk)
   begin
      if (ce && we)
      begin
         if (byte_op)
         begin
            // byte data always comes in on the low lane
            if (addr[0])
               mem[word_index][15:8] <= data_in[7:0];
            else
               mem[word_index][7:0] <= data_in[7:0];
         end
         else
         begin
            mem[word_index] <= data_in;
         end
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bus testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_bus \
   -Mdir obj_dir > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat "$build_log"
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_bus > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$sim_log"; then
   exit 1
fi
exit 0

// ==== test/bus_checker.sv ====
/*
 * testbench checker: compares bus outputs with expected values,
 * counts errors per test and over the whole run
 */
`timescale 1ns/1ps
`default_nettype none

module bus_checker
(
   input wire        clk,
   input wire [15:0] data_out,
   input wire        bus_ack,
   input wire        bus_error,
   input wire        interrupt,
   input wire  [7:0] vector,
   input wire        psw_io_wr,
   input wire [15:0] display
);

   int error_count  = 0;
   int test_errors  = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int psw_pulses   = 0;

   task automatic compare(input string name, input logic [15:0] got,
                          input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
         test_errors++;
         error_count++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("failure at %0d ns: %s", $time, msg);
      test_errors++;
      error_count++;
   endtask

   task automatic check_data(input logic [15:0] exp);
      compare("data_out", data_out, exp);
   endtask

   task automatic check_ack(input logic exp);
      compare("bus_ack", {15'd0, bus_ack}, {15'd0, exp});
   endtask

   task automatic check_error(input logic exp);
      compare("bus_error", {15'd0, bus_error}, {15'd0, exp});
   endtask

   task automatic check_interrupt(input logic exp);
      compare("interrupt", {15'd0, interrupt}, {15'd0, exp});
   endtask

   task automatic check_vector(input logic [7:0] exp);
      compare("vector", {8'd0, vector}, {8'd0, exp});
   endtask

   task automatic check_psw_io_wr(input logic exp);
      compare("psw_io_wr", {15'd0, psw_io_wr}, {15'd0, exp});
   endtask

   task automatic check_display(input logic [15:0] exp);
      compare("display", display, exp);
   endtask

   task automatic check_psw_pulses(input int exp);
      compare("psw_io_wr cycles", 16'(psw_pulses), 16'(exp));
   endtask

   task automatic clear_psw_pulses();
      psw_pulses = 0;
   endtask

   // psw strobe has to fall in a cycle the cpu owns
   always @(negedge clk)
   begin
      if (psw_io_wr)
      begin
         psw_pulses++;
         if (!bus_ack)
            note_failure("psw_io_wr went high while the dma held the bus");
      end
   end

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("test %0d %s: passed", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic report();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
               error_count);
   endtask

endmodule

`default_nettype wire

// ==== test/tb_bus.sv ====
/*
 * testbench top for the memory and i/o bus: table driven cpu cycles
 * against a ram model, register checks and a fill dma run
 */
`timescale 1ns/1ps
`default_nettype none

`include "bus_consts.svh"

module tb_bus;

   import bus_pkg::*;

   localparam logic [2:0] OP_WRITE     = 3'd0;
   localparam logic [2:0] OP_BYTE      = 3'd1;
   localparam logic [2:0] OP_READ      = 3'd2;
   localparam logic [2:0] OP_READ_ERR  = 3'd3;
   localparam logic [2:0] OP_WRITE_ERR = 3'd4;
   localparam int ACK_LIMIT  = 20;
   localparam int FILL_LIMIT = 500;
   localparam int FILL_WORDS = 12;
   localparam logic [15:0] FILL_BYTES = 16'd24;
   localparam logic [15:0] CSR_GO_IE =
      (16'd1 << `BUS_FILL_GO_BIT) | (16'd1 << `BUS_FILL_IE_BIT);
   localparam logic [15:0] CSR_DONE_IE =
      (16'd1 << `BUS_FILL_DONE_BIT) | (16'd1 << `BUS_FILL_IE_BIT);

   // for reads the data field holds the expected word
   typedef struct packed
   {
      logic  [2:0] kind;
      logic [21:0] addr;
      logic [15:0] data;
   } op_t;

   logic        clk;
   logic        reset;
   cpu_bus_t    cpu;
   logic [15:0] psw;
   logic [15:0] switches;
   logic [15:0] data_out;
   logic        bus_ack;
   logic        bus_error;
   logic        interrupt;
   logic  [7:0] vector;
   logic        psw_io_wr;
   logic [15:0] display;

   op_t         ops[$];
   logic [15:0] model [0:`BUS_RAM_WORDS-1];
   logic [31:0] rand_state;
   logic [15:0] ram_addrs [0:7];
   int          wait_cycles;

   tb_clock i_clock (.*);

   bus i_dut (.*);

   bus_checker i_chk (.*);

   function automatic logic [15:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state[31:16];
   endfunction

   function automatic logic [15:0] random_ram_addr();
      logic [15:0] a;
      a = next_random() & 16'hfffe;
      if (&a[15:13])
         a[15] = 1'b0;
      return a;
   endfunction

   // bits 21:16 are not decoded, so they carry noise
   task automatic add_op(input logic [2:0] kind, input logic [15:0] addr,
                         input logic [15:0] data);
      op_t         op;
      logic [15:0] noise;
      noise   = next_random();
      op.kind = kind;
      op.addr = {noise[5:0], addr};
      op.data = data;
      ops.push_back(op);
   endtask

   task automatic ram_write(input logic [15:0] addr, input logic [15:0] data);
      add_op(OP_WRITE, addr, data);
      model[addr[14:1]] = data;
   endtask

   task automatic ram_byte_write(input logic [15:0] addr, input logic [15:0] data);
      add_op(OP_BYTE, addr, data);
      if (addr[0])
         model[addr[14:1]][15:8] = data[7:0];
      else
         model[addr[14:1]][7:0] = data[7:0];
   endtask

   task automatic ram_read(input logic [15:0] addr);
      add_op(OP_READ, addr, model[addr[14:1]]);
   endtask

   // starts on a rising edge and holds each cycle until bus_ack
   task automatic apply_ops();
      op_t      op;
      cpu_bus_t req;
      int       n;
      foreach (ops[i])
      begin
         op          = ops[i];
         req.addr    = op.addr;
         req.data    = op.data;
         req.rd      = (op.kind == OP_READ) || (op.kind == OP_READ_ERR);
         req.wr      = !req.rd;
         req.byte_op = (op.kind == OP_BYTE);
         cpu <= req;
         n = 0;
         @(negedge clk);
         while (!bus_ack && n < ACK_LIMIT)
         begin
            n++;
            wait_cycles++;
            @(negedge clk);
         end
         if (!bus_ack)
            i_chk.note_failure("cpu cycle never got bus_ack");
         i_chk.check_error((op.kind == OP_READ_ERR) || (op.kind == OP_WRITE_ERR));
         i_chk.check_psw_io_wr((op.kind == OP_WRITE) && (op.addr[15:0] == `BUS_PSW_ADDR));
         if (op.kind == OP_READ)
            i_chk.check_data(op.data);
         @(posedge clk);
      end
      cpu <= '0;
      ops.delete();
   endtask

   task automatic wait_interrupt();
      int n;
      n = 0;
      @(negedge clk);
      while (!interrupt && n < FILL_LIMIT)
      begin
         n++;
         @(negedge clk);
      end
      if (!interrupt)
         i_chk.note_failure("fill dma never raised interrupt");
   endtask

   initial
   begin
      logic [15:0] base;
      logic [15:0] pattern;
      logic [15:0] busy_addrs [0:3];
      logic [15:0] d;
      int          n;

      rand_state  = 32'h23554ec9;
      wait_cycles = 0;
      cpu         = '0;
      psw         = next_random();
      switches    = next_random();

      n = 0;
      @(posedge clk);
      while (reset && n < 10)
      begin
         n++;
         @(posedge clk);
      end
      if (reset)
         i_chk.note_failure("reset was never released");

      @(negedge clk);
      i_chk.check_ack(1'b1);
      i_chk.check_error(1'b0);
      i_chk.check_interrupt(1'b0);
      i_chk.check_vector(8'd0);
      i_chk.check_psw_io_wr(1'b0);
      i_chk.check_display(16'd0);
      @(posedge clk);
      add_op(OP_READ, `BUS_FILL_ADDR_REG, 16'd0);
      add_op(OP_READ, `BUS_FILL_COUNT_REG, 16'd0);
      add_op(OP_READ, `BUS_FILL_DATA_REG, 16'd0);
      add_op(OP_READ, `BUS_FILL_CSR_REG, 16'd0);
      apply_ops();
      i_chk.end_test("reset state");

      for (int i = 0; i < 8; i++)
      begin
         ram_addrs[i] = random_ram_addr();
         ram_write(ram_addrs[i], next_random());
      end
      for (int i = 0; i < 8; i++)
      begin
         ram_read(ram_addrs[i]);
         // bit 15 is not decoded so the other half aliases
         d = ram_addrs[i] ^ 16'h8000;
         if (!(&d[15:13]))
            ram_read(d);
      end
      apply_ops();
      i_chk.end_test("ram words");

      for (int i = 0; i < 4; i++)
      begin
         d = next_random();
         ram_byte_write(ram_addrs[i] | {15'd0, d[8]}, next_random());
      end
      for (int i = 0; i < 4; i++)
         ram_read(ram_addrs[i]);
      apply_ops();
      i_chk.end_test("byte writes");

      i_chk.clear_psw_pulses();
      add_op(OP_READ, `BUS_PSW_ADDR, psw);
      add_op(OP_WRITE, `BUS_PSW_ADDR, next_random());
      add_op(OP_READ, `BUS_PSW_ADDR, psw);
      apply_ops();
      @(negedge clk);
      i_chk.check_psw_io_wr(1'b0);
      i_chk.check_psw_pulses(1);
      @(posedge clk);
      i_chk.end_test("psw access");

      d = next_random();
      add_op(OP_READ, `BUS_SWR_ADDR, switches);
      add_op(OP_WRITE, `BUS_SWR_ADDR, d);
      apply_ops();
      @(negedge clk);
      i_chk.check_display(d);
      @(posedge clk);
      add_op(OP_BYTE, `BUS_SWR_ADDR + 16'd1, 16'h00a5);
      apply_ops();
      @(negedge clk);
      i_chk.check_display({8'ha5, d[7:0]});
      @(posedge clk);
      i_chk.end_test("switch register");

      add_op(OP_READ_ERR, 16'o160000, 16'd0);
      add_op(OP_WRITE_ERR, 16'o177000, next_random());
      add_op(OP_READ_ERR, 16'o177710, 16'd0);
      add_op(OP_WRITE_ERR, 16'o177774, next_random());
      ram_read(ram_addrs[5]);
      add_op(OP_READ, `BUS_SWR_ADDR, switches);
      add_op(OP_READ, `BUS_FILL_CSR_REG, 16'd0);
      apply_ops();
      i_chk.end_test("bus error");

      i_chk.clear_psw_pulses();
      base    = 16'h2000 | (next_random() & 16'h0ffe);
      pattern = next_random();
      ram_write(base - 16'd2, next_random());
      ram_write(base + FILL_BYTES, next_random());
      for (int i = 0; i < 4; i++)
      begin
         busy_addrs[i] = next_random() & 16'h0ffe;
         ram_write(busy_addrs[i], next_random());
      end
      add_op(OP_WRITE, `BUS_FILL_ADDR_REG, base);
      add_op(OP_WRITE, `BUS_FILL_COUNT_REG, 16'(FILL_WORDS));
      add_op(OP_WRITE, `BUS_FILL_DATA_REG, pattern);
      add_op(OP_WRITE, `BUS_FILL_CSR_REG, CSR_GO_IE);
      // these cycles compete with the running fill
      for (int i = 0; i < 4; i++)
         ram_read(busy_addrs[i]);
      add_op(OP_WRITE, `BUS_PSW_ADDR, next_random());
      for (int i = 0; i < 4; i++)
         ram_read(busy_addrs[i]);
      n = wait_cycles;
      apply_ops();
      if (wait_cycles == n)
         i_chk.note_failure("cpu cycles never waited for the dma");
      wait_interrupt();
      i_chk.check_interrupt(1'b1);
      i_chk.check_vector(`BUS_FILL_VECTOR);
      i_chk.check_psw_pulses(1);
      for (int i = 0; i < FILL_WORDS; i++)
      begin
         d = base + 16'(2 * i);
         model[d[14:1]] = pattern;
      end
      @(posedge clk);
      for (int i = -1; i <= FILL_WORDS; i++)
         ram_read(base + 16'(2 * i));
      add_op(OP_READ, `BUS_FILL_CSR_REG, CSR_DONE_IE);
      add_op(OP_READ, `BUS_FILL_COUNT_REG, 16'd0);
      add_op(OP_READ, `BUS_FILL_ADDR_REG, base + FILL_BYTES);
      add_op(OP_WRITE, `BUS_FILL_CSR_REG, 16'd0);
      add_op(OP_READ, `BUS_FILL_CSR_REG, 16'd0);
      apply_ops();
      @(negedge clk);
      i_chk.check_interrupt(1'b0);
      i_chk.check_vector(8'd0);
      i_chk.end_test("fill dma");

      i_chk.report();
      if (i_chk.error_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
/*
 * testbench clock and reset, 40 ns period,
 * reset held for the first 3 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk   = 1'b0;
      reset = 1'b1;
      forever #20 clk = ~clk;
   end

   initial
   begin
      repeat (3) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire
